/* common/sdram_pkg.sv */
package sdram_pkg;

    // Pin widths of the 16-bit SDR part
    localparam int ROW_WIDTH  = 13;
    localparam int COL_WIDTH  = 9;
    localparam int BANK_WIDTH = 2;
    localparam int DATA_WIDTH = 16;
    localparam int DQM_WIDTH  = 2;

    // Row bits kept by the model array
    localparam int MODEL_ROW_BITS = 4;

    // Access shape
    localparam int BURST_LEN   = 4;
    localparam int BURST_CODE  = 2;
    localparam int CAS_LATENCY = 2;

    // Power-up wait before the first command
    localparam int INIT_WAIT = 16;

    // A10 selects all banks on PRECHARGE, auto precharge on READ/WRITE
    localparam int ALL_BANKS_BIT = 10;

    // Command pins {cs, ras, cas, we}, all active low
    typedef enum logic [3:0] {
        INHIBIT      = 4'b1111,
        NOP          = 4'b0111,
        ACTIVE       = 4'b0011,
        READ         = 4'b0101,
        WRITE        = 4'b0100,
        PRECHARGE    = 4'b0010,
        AUTO_REFRESH = 4'b0001,
        LOAD_MODE    = 4'b0000
    } sdram_cmd_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Everything the controller puts on the pins except dq
    typedef struct packed {
        sdram_cmd_e                cmd;
        logic [BANK_WIDTH-1:0]     ba;
        logic [ROW_WIDTH-1:0]      a;
        logic [DQM_WIDTH-1:0]      dqm;
    } sdram_cmd_t;

    // One access, word 0 at index 0
    // A set mask bit blanks that byte
    typedef struct packed {
        mem_op_e                                    op;
        logic [BANK_WIDTH-1:0]                      bank;
        logic [ROW_WIDTH-1:0]                       row;
        logic [COL_WIDTH-1:0]                       col;
        logic [BURST_LEN-1:0][DATA_WIDTH-1:0]       data;
        logic [BURST_LEN-1:0][DQM_WIDTH-1:0]        mask;
    } mem_req_t;

    // Read data, word 0 at index 0
    typedef struct packed {
        logic [BURST_LEN-1:0][DATA_WIDTH-1:0]       data;
    } mem_rsp_t;

endpackage

/* sdram/sdram.sv */
`timescale 1ns/1ps

module sdram (
    input  logic                                clk,
    input  logic                                cke,
    input  logic                                cs,
    input  logic                                ras,
    input  logic                                cas,
    input  logic                                we,
    input  logic [sdram_pkg::ROW_WIDTH-1:0]     a,
    input  logic [sdram_pkg::BANK_WIDTH-1:0]    ba,
    input  logic [sdram_pkg::DQM_WIDTH-1:0]     dqm,
    inout  wire  [sdram_pkg::DATA_WIDTH-1:0]    dq
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READ,
        READING,
        WRITING
    } state_e;

    // Bank, stored row bits, column
    logic [sdram_pkg::DATA_WIDTH-1:0] mem
        [1 << sdram_pkg::BANK_WIDTH]
        [1 << sdram_pkg::MODEL_ROW_BITS]
        [1 << sdram_pkg::COL_WIDTH];

    logic [sdram_pkg::ROW_WIDTH-1:0]    active_row [1 << sdram_pkg::BANK_WIDTH];

    // Mode register fields
    logic [2:0]                         burst_code;
    logic [2:0]                         cas_code;
    logic [3:0]                         burst_len;

    sdram_pkg::sdram_cmd_e              cmd;
    logic [sdram_pkg::DATA_WIDTH-1:0]   masked_dq;
    logic [sdram_pkg::DATA_WIDTH-1:0]   rd_word;

    state_e                             state;
    logic [2:0]                         delay_cnt;
    logic [3:0]                         burst_cnt;
    logic [sdram_pkg::COL_WIDTH-1:0]    cur_col;
    logic [sdram_pkg::BANK_WIDTH-1:0]   cur_bank;

    logic [sdram_pkg::DATA_WIDTH-1:0]   dq_out;
    logic                               dq_en;

    // Part powers up with an empty array and an idle burst engine
    initial begin
        state = IDLE;
        dq_en = 1'b0;
        for (int b = 0; b < (1 << sdram_pkg::BANK_WIDTH); b++) begin
            for (int r = 0; r < (1 << sdram_pkg::MODEL_ROW_BITS); r++) begin
                for (int c = 0; c < (1 << sdram_pkg::COL_WIDTH); c++) begin
                    mem[b][r][c] = '0;
                end
            end
        end
    end

    // Deselected chip reads as INHIBIT whatever the other pins do
    assign cmd = cs ? sdram_pkg::INHIBIT : sdram_pkg::sdram_cmd_e'({cs, ras, cas, we});

    // Masked bytes go in as zero
    assign masked_dq[7:0]  = dqm[0] ? 8'h00 : dq[7:0];
    assign masked_dq[15:8] = dqm[1] ? 8'h00 : dq[15:8];

    // Word at the current burst column
    assign rd_word = mem[cur_bank][active_row[cur_bank][sdram_pkg::MODEL_ROW_BITS-1:0]][cur_col];

    assign dq = dq_en ? dq_out : 'z;

    always_comb begin
        case (burst_code)
            3'd0:    burst_len = 4'd1;
            3'd1:    burst_len = 4'd2;
            3'd2:    burst_len = 4'd4;
            3'd3:    burst_len = 4'd8;
            default: burst_len = 4'd1;
        endcase
    end

    always @(posedge clk) begin
        if (!cke) begin
            state <= IDLE;
            dq_en <= 1'b0;
        end else begin
            // Burst engine first, a new command below takes over
            case (state)
                IDLE: begin
                end
                WAIT_READ: begin
                    if (delay_cnt > 0) begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                    // First word goes out one cycle ahead of its sample edge
                    if (delay_cnt <= 3'd1) begin
                        dq_out  <= rd_word;
                        dq_en   <= 1'b1;
                        cur_col <= cur_col + 1'b1;
                        state   <= READING;
                    end
                end
                READING: begin
                    if (burst_cnt != 0) begin
                        burst_cnt <= burst_cnt - 1'b1;
                        cur_col   <= cur_col + 1'b1;
                        dq_out    <= rd_word;
                    end else begin
                        // Release the bus after the last beat
                        dq_en <= 1'b0;
                        state <= IDLE;
                    end
                end
                WRITING: begin
                    if (burst_cnt != 0) begin
                        burst_cnt <= burst_cnt - 1'b1;
                        cur_col   <= cur_col + 1'b1;
                        mem[cur_bank][active_row[cur_bank][sdram_pkg::MODEL_ROW_BITS-1:0]]
                           [cur_col + 1'b1] <= masked_dq;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (cmd == sdram_pkg::LOAD_MODE) begin
                burst_code <= a[2:0];
                cas_code   <= a[6:4];
            end else if (cmd == sdram_pkg::ACTIVE) begin
                // Only one bank keeps an open row
                for (int b = 0; b < (1 << sdram_pkg::BANK_WIDTH); b++) begin
                    active_row[b] <= (b == int'(ba)) ? a : '0;
                end
                state <= IDLE;
            end else if (cmd == sdram_pkg::READ) begin
                delay_cnt <= cas_code - 1'b1;
                burst_cnt <= burst_len - 1'b1;
                cur_col   <= a[sdram_pkg::COL_WIDTH-1:0];
                cur_bank  <= ba;
                state     <= WAIT_READ;
            end else if (cmd == sdram_pkg::WRITE) begin
                // Word 0 is stored in the command cycle itself
                burst_cnt <= burst_len - 1'b1;
                cur_col   <= a[sdram_pkg::COL_WIDTH-1:0];
                cur_bank  <= ba;
                mem[ba][active_row[ba][sdram_pkg::MODEL_ROW_BITS-1:0]]
                   [a[sdram_pkg::COL_WIDTH-1:0]] <= masked_dq;
                state     <= WRITING;
            end
        end
    end

endmodule

/* sdram_ctrl/sdram_cmd_seq.sv */
`timescale 1ns/1ps

module sdram_cmd_seq (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid,
    input  sdram_pkg::mem_req_t                 req,
    output logic                                ready,
    input  logic                                rd_done,
    output logic                                rd_start,
    output sdram_pkg::sdram_cmd_t               cmd,
    inout  wire  [sdram_pkg::DATA_WIDTH-1:0]    dq
);

    typedef enum logic [3:0] {
        INIT_WAIT,
        INIT_PRECHARGE,
        INIT_MODE,
        IDLE,
        ACTIVATE,
        WRITE_BURST,
        READ_ISSUE,
        READ_WAIT,
        PRECHARGE
    } state_e;

    state_e state;

    logic [$clog2(sdram_pkg::INIT_WAIT)-1:0]    wait_cnt;
    // One extra bit so the count can reach BURST_LEN
    logic [$clog2(sdram_pkg::BURST_LEN):0]      beat;
    logic [$clog2(sdram_pkg::BURST_LEN)-1:0]    beat_idx;

    sdram_pkg::mem_req_t                        req_q;
    logic [sdram_pkg::DATA_WIDTH-1:0]           dq_out;
    logic                                       dq_en;

    // Requests only taken in IDLE
    assign ready    = (state == IDLE);
    // READ is on the pins for exactly this state
    assign rd_start = (state == READ_ISSUE);

    assign beat_idx = beat[$clog2(sdram_pkg::BURST_LEN)-1:0];

    // Write data only while a burst is being sent
    assign dq = dq_en ? dq_out : 'z;

    // Request latch and write word pipeline
    always_ff @(posedge clk) begin
        if (ready && req_valid) begin
            req_q <= req;
        end
        // Word for the next beat, lines up with cmd.dqm
        dq_out <= req_q.data[beat_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= INIT_WAIT;
            wait_cnt <= '0;
            beat     <= '0;
            dq_en    <= 1'b0;
            cmd      <= '{cmd: sdram_pkg::NOP, ba: '0, a: '0, dqm: '0};
        end else begin
            // Pins fall back to NOP unless a state says otherwise
            cmd.cmd <= sdram_pkg::NOP;
            case (state)
                INIT_WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == ($clog2(sdram_pkg::INIT_WAIT))'(sdram_pkg::INIT_WAIT - 1)) begin
                        // Close every bank before the mode write
                        cmd.cmd                          <= sdram_pkg::PRECHARGE;
                        cmd.a                            <= '0;
                        cmd.a[sdram_pkg::ALL_BANKS_BIT]  <= 1'b1;
                        state                            <= INIT_PRECHARGE;
                    end
                end
                INIT_PRECHARGE: begin
                    // Sequential burst, burst length and CAS latency fields
                    cmd.cmd    <= sdram_pkg::LOAD_MODE;
                    cmd.ba     <= '0;
                    cmd.a      <= '0;
                    cmd.a[2:0] <= 3'(sdram_pkg::BURST_CODE);
                    cmd.a[6:4] <= 3'(sdram_pkg::CAS_LATENCY);
                    state      <= INIT_MODE;
                end
                INIT_MODE: begin
                    state <= IDLE;
                end
                IDLE: begin
                    if (req_valid) begin
                        // Open the row, burst starts next cycle
                        cmd.cmd <= sdram_pkg::ACTIVE;
                        cmd.ba  <= req.bank;
                        cmd.a   <= req.row;
                        beat    <= '0;
                        state   <= ACTIVATE;
                    end
                end
                ACTIVATE: begin
                    // Column on the low bits, A10 low so no auto precharge
                    cmd.a <= sdram_pkg::ROW_WIDTH'(req_q.col);
                    if (req_q.op == sdram_pkg::OP_WRITE) begin
                        cmd.cmd <= sdram_pkg::WRITE;
                        cmd.dqm <= req_q.mask[beat_idx];
                        dq_en   <= 1'b1;
                        beat    <= beat + 1'b1;
                        state   <= WRITE_BURST;
                    end else begin
                        cmd.cmd <= sdram_pkg::READ;
                        cmd.dqm <= '0;
                        state   <= READ_ISSUE;
                    end
                end
                WRITE_BURST: begin
                    if (beat == ($clog2(sdram_pkg::BURST_LEN) + 1)'(sdram_pkg::BURST_LEN)) begin
                        // Last word went out on the previous cycle
                        cmd.cmd                          <= sdram_pkg::PRECHARGE;
                        cmd.a                            <= '0;
                        cmd.a[sdram_pkg::ALL_BANKS_BIT]  <= 1'b1;
                        cmd.dqm                          <= '0;
                        dq_en                            <= 1'b0;
                        state                            <= PRECHARGE;
                    end else begin
                        cmd.dqm <= req_q.mask[beat_idx];
                        beat    <= beat + 1'b1;
                    end
                end
                READ_ISSUE: begin
                    state <= READ_WAIT;
                end
                READ_WAIT: begin
                    // Hold the row open until the capture stage has all beats
                    if (rd_done) begin
                        cmd.cmd                          <= sdram_pkg::PRECHARGE;
                        cmd.a                            <= '0;
                        cmd.a[sdram_pkg::ALL_BANKS_BIT]  <= 1'b1;
                        state                            <= PRECHARGE;
                    end
                end
                PRECHARGE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* sdram_ctrl/sdram_rd_capture.sv */
`timescale 1ns/1ps

module sdram_rd_capture (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                rd_start,
    input  logic [sdram_pkg::DATA_WIDTH-1:0]    dq,
    output logic                                rsp_valid,
    output sdram_pkg::mem_rsp_t                 rsp,
    output logic                                rd_done
);

    logic                                       waiting;
    logic                                       capturing;
    logic [2:0]                                 lat_cnt;
    logic [$clog2(sdram_pkg::BURST_LEN)-1:0]    beat_cnt;

    // Sequencer sees the same pulse as the outside
    assign rd_done = rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            waiting   <= 1'b0;
            capturing <= 1'b0;
            lat_cnt   <= '0;
            beat_cnt  <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (rd_start) begin
                // Beat 0 arrives CAS_LATENCY + 1 edges after rd_start rises
                waiting <= 1'b1;
                lat_cnt <= 3'(sdram_pkg::CAS_LATENCY - 1);
            end else if (waiting) begin
                lat_cnt <= lat_cnt - 1'b1;
                if (lat_cnt <= 3'd1) begin
                    waiting   <= 1'b0;
                    capturing <= 1'b1;
                    beat_cnt  <= '0;
                end
            end else if (capturing) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == ($clog2(sdram_pkg::BURST_LEN))'(sdram_pkg::BURST_LEN - 1)) begin
                    capturing <= 1'b0;
                    rsp_valid <= 1'b1;
                end
            end
        end
    end

    // Each beat lands in its own word slot
    always_ff @(posedge clk) begin
        if (capturing) begin
            rsp.data[beat_cnt] <= dq;
        end
    end

endmodule

/* logic/sdram_sys.sv */
`timescale 1ns/1ps

module sdram_sys (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  sdram_pkg::mem_req_t     req,
    output logic                    ready,
    output logic                    rsp_valid,
    output sdram_pkg::mem_rsp_t     rsp
);

    sdram_pkg::sdram_cmd_t              cmd;

    // Shared data bus, sequencer on writes and model on reads
    wire [sdram_pkg::DATA_WIDTH-1:0]    dq;

    // Command pins
    wire                                cs;
    wire                                ras;
    wire                                cas;
    wire                                we;
    wire [sdram_pkg::ROW_WIDTH-1:0]     a;
    wire [sdram_pkg::BANK_WIDTH-1:0]    ba;
    wire [sdram_pkg::DQM_WIDTH-1:0]     dqm;

    logic                               rd_start;
    logic                               rd_done;

    assign {cs, ras, cas, we} = cmd.cmd;
    assign a                  = cmd.a;
    assign ba                 = cmd.ba;
    assign dqm                = cmd.dqm;

    sdram_cmd_seq i_cmd_seq (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .rd_done   (rd_done),
        .rd_start  (rd_start),
        .cmd       (cmd),
        .dq        (dq)
    );

    // No power-down, clock always enabled
    sdram i_sdram (
        .clk (clk),
        .cke (1'b1),
        .cs  (cs),
        .ras (ras),
        .cas (cas),
        .we  (we),
        .a   (a),
        .ba  (ba),
        .dqm (dqm),
        .dq  (dq)
    );

    sdram_rd_capture i_rd_capture (
        .clk       (clk),
        .reset     (reset),
        .rd_start  (rd_start),
        .dq        (dq),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rd_done   (rd_done)
    );

endmodule

/* dv/sdram_sys_assertions.sv */
`timescale 1ns/1ps

module sdram_sys_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     req_valid,
    input logic                     ready,
    input logic                     rsp_valid,
    input sdram_pkg::sdram_cmd_t    cmd
);

    // Set by ACTIVE, cleared by PRECHARGE
    logic row_open;

    always_ff @(posedge clk) begin
        if (reset) begin
            row_open <= 1'b0;
        end else if (cmd.cmd == sdram_pkg::ACTIVE) begin
            row_open <= 1'b1;
        end else if (cmd.cmd == sdram_pkg::PRECHARGE) begin
            row_open <= 1'b0;
        end
    end

    rsp_single_pulse: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid high on two cycles in a row");

    // Column commands need an open row
    col_needs_row: assert property (@(posedge clk) disable iff (reset)
        (cmd.cmd == sdram_pkg::READ || cmd.cmd == sdram_pkg::WRITE) |-> row_open)
        else $error("READ or WRITE issued with no ACTIVE since the last PRECHARGE");

    busy_after_accept: assert property (@(posedge clk) disable iff (reset)
        (ready && req_valid) |=> !ready)
        else $error("ready still high the cycle after a request was taken");

    // Mode write belongs to initialization only
    mode_during_init: assert property (@(posedge clk) disable iff (reset)
        (cmd.cmd == sdram_pkg::LOAD_MODE) |-> !ready)
        else $error("LOAD_MODE issued while ready was high");

endmodule

bind sdram_sys sdram_sys_assertions i_sdram_sys_assertions (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .ready     (ready),
    .rsp_valid (rsp_valid),
    .cmd       (cmd)
);

/* dv/sdram_sys_tb.sv */
`timescale 1ns/1ps

module sdram_sys_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int N_ENTRIES    = 25;
    // Budget per table entry, plus power-up wait and slack
    localparam int WATCHDOG_CYCLES =
        N_ENTRIES * 40 + sdram_pkg::INIT_WAIT + RESET_CYCLES + 100;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    sdram_pkg::mem_req_t    req;
    logic                   ready;
    logic                   rsp_valid;
    sdram_pkg::mem_rsp_t    rsp;

    // Request table and the response each read must return
    sdram_pkg::mem_req_t    stim_req [N_ENTRIES];
    sdram_pkg::mem_rsp_t    stim_exp [N_ENTRIES];
    int                     n_built = 0;

    // Expected array image: bank, low row bits, column
    logic [sdram_pkg::DATA_WIDTH-1:0] shadow
        [1 << sdram_pkg::BANK_WIDTH]
        [1 << sdram_pkg::MODEL_ROW_BITS]
        [1 << sdram_pkg::COL_WIDTH];

    logic [31:0]            lfsr;
    string                  wait_what = "reset release";
    int                     rsp_seen = 0;
    int                     reads_sent = 0;
    sdram_pkg::mem_req_t    init_intruder;
    sdram_pkg::mem_req_t    busy_intruder;

    sdram_sys i_sdram_sys (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Every response pulse, whatever request it belongs to
    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            rsp_seen++;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [sdram_pkg::DATA_WIDTH-1:0] word);
        word = '0;
        for (int i = 0; i < sdram_pkg::DATA_WIDTH; i++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[sdram_pkg::DATA_WIDTH-2:0], lfsr[0]};
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic add_entry(input sdram_pkg::mem_op_e op, input logic [1:0] bank,
                             input logic [12:0] row, input logic [8:0] col,
                             input logic [7:0] mask);
        sdram_pkg::mem_req_t r;
        logic [sdram_pkg::DATA_WIDTH-1:0] w;
        r      = '0;
        r.op   = op;
        r.bank = bank;
        r.row  = row;
        r.col  = col;
        // Reads carry no data or mask
        if (op == sdram_pkg::OP_WRITE) begin
            for (int i = 0; i < sdram_pkg::BURST_LEN; i++) begin
                random_word(w);
                r.data[i] = w;
            end
            r.mask = mask;
        end
        stim_req[n_built] = r;
        n_built++;
    endtask

    // Walk the table in order: word i lands at col + i, masked bytes become zero
    task automatic compute_expected();
        logic [sdram_pkg::DATA_WIDTH-1:0]       word;
        logic [sdram_pkg::COL_WIDTH-1:0]        c;
        logic [sdram_pkg::MODEL_ROW_BITS-1:0]   row_lo;
        for (int bi = 0; bi < (1 << sdram_pkg::BANK_WIDTH); bi++) begin
            for (int ri = 0; ri < (1 << sdram_pkg::MODEL_ROW_BITS); ri++) begin
                for (int ci = 0; ci < (1 << sdram_pkg::COL_WIDTH); ci++) begin
                    shadow[bi][ri][ci] = '0;
                end
            end
        end
        for (int n = 0; n < N_ENTRIES; n++) begin
            stim_exp[n] = '0;
            row_lo = stim_req[n].row[sdram_pkg::MODEL_ROW_BITS-1:0];
            for (int i = 0; i < sdram_pkg::BURST_LEN; i++) begin
                c = stim_req[n].col + 9'(i);
                if (stim_req[n].op == sdram_pkg::OP_WRITE) begin
                    word = stim_req[n].data[i];
                    if (stim_req[n].mask[i][0]) begin
                        word[7:0] = 8'h00;
                    end
                    if (stim_req[n].mask[i][1]) begin
                        word[15:8] = 8'h00;
                    end
                    shadow[stim_req[n].bank][row_lo][c] = word;
                end else begin
                    stim_exp[n].data[i] = shadow[stim_req[n].bank][row_lo][c];
                end
            end
        end
    endtask

    task automatic check_ready(input bit exp);
        if (ready !== exp) begin
            report_failure($sformatf("Fail ready: got %h expected %h", ready, exp));
        end
    endtask

    task automatic check_rsp(input int n, input sdram_pkg::mem_rsp_t got,
                             input sdram_pkg::mem_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail rsp entry %0d: got %h expected %h",
                                     n, got.data, exp.data));
        end
    endtask

    task automatic check_rsp_count(input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("Fail rsp_valid pulses: got %h expected %h", got, exp));
        end
    endtask

    task automatic wait_for_ready();
        while (ready !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_for_rsp();
        while (rsp_valid !== 1'b1) @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Timeout while waiting for %s", wait_what));
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        lfsr      = 32'h2e465323;

        // Basic write then read back
        add_entry(sdram_pkg::OP_WRITE, 2'd0, 13'd1, 9'h010, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd0, 13'd1, 9'h010, 8'h00);
        // Mixed byte masks across the four words
        add_entry(sdram_pkg::OP_WRITE, 2'd1, 13'd2, 9'h020, 8'h6c);
        add_entry(sdram_pkg::OP_READ,  2'd1, 13'd2, 9'h020, 8'h00);
        // Same row and column in every bank
        for (int b = 0; b < 4; b++) begin
            add_entry(sdram_pkg::OP_WRITE, 2'(b), 13'd3, 9'h080, 8'h00);
        end
        for (int b = 0; b < 4; b++) begin
            add_entry(sdram_pkg::OP_READ, 2'(b), 13'd3, 9'h080, 8'h00);
        end
        // Overlap shifted by two columns, then reads around it
        add_entry(sdram_pkg::OP_WRITE, 2'd2, 13'd7, 9'h100, 8'h00);
        add_entry(sdram_pkg::OP_WRITE, 2'd2, 13'd7, 9'h102, 8'h03);
        add_entry(sdram_pkg::OP_READ,  2'd2, 13'd7, 9'h100, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd2, 13'd7, 9'h102, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd2, 13'd7, 9'h0fe, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd3, 13'd9, 9'h1f0, 8'h00);
        // Targets of the ignored requests
        add_entry(sdram_pkg::OP_READ,  2'd3, 13'd5, 9'h040, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd3, 13'd6, 9'h050, 8'h00);
        // Repeated addresses back to back
        add_entry(sdram_pkg::OP_WRITE, 2'd1, 13'd2, 9'h020, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd1, 13'd2, 9'h020, 8'h00);
        add_entry(sdram_pkg::OP_WRITE, 2'd1, 13'd2, 9'h022, 8'h30);
        add_entry(sdram_pkg::OP_READ,  2'd1, 13'd2, 9'h020, 8'h00);
        add_entry(sdram_pkg::OP_READ,  2'd0, 13'd1, 9'h010, 8'h00);
        compute_expected();

        init_intruder      = '0;
        init_intruder.op   = sdram_pkg::OP_WRITE;
        init_intruder.bank = 2'd3;
        init_intruder.row  = 13'd5;
        init_intruder.col  = 9'h040;
        init_intruder.data = {4{16'hbeef}};
        busy_intruder      = init_intruder;
        busy_intruder.row  = 13'd6;
        busy_intruder.col  = 9'h050;
        busy_intruder.data = {4{16'h5a5a}};

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_ready(1'b0);

        // Still initializing, so this strobe must be dropped
        req_valid = 1'b1;
        req       = init_intruder;
        @(negedge clk);
        check_ready(1'b0);
        req_valid = 1'b0;
        req       = '0;

        wait_what = "ready after initialization";
        wait_for_ready();

        for (int n = 0; n < N_ENTRIES; n++) begin
            wait_what = $sformatf("ready before entry %0d", n);
            wait_for_ready();
            req_valid = 1'b1;
            req       = stim_req[n];
            @(negedge clk);
            // Taken on the last edge, busy from here on
            check_ready(1'b0);
            req = busy_intruder;
            @(negedge clk);
            req_valid = 1'b0;
            req       = '0;
            if (stim_req[n].op == sdram_pkg::OP_READ) begin
                wait_what = $sformatf("rsp_valid of entry %0d", n);
                wait_for_rsp();
                check_rsp(n, rsp, stim_exp[n]);
                reads_sent++;
            end
        end

        wait_what = "ready after the last access";
        wait_for_ready();
        @(negedge clk);
        check_rsp_count(rsp_seen, reads_sent);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verilog.f */
common/sdram_pkg.sv
sdram/sdram.sv
sdram_ctrl/sdram_cmd_seq.sv
sdram_ctrl/sdram_rd_capture.sv
logic/sdram_sys.sv
dv/sdram_sys_assertions.sv
dv/sdram_sys_tb.sv

/* Makefile */
# Verilator build and run of the SDRAM subsystem testbench
TOP := sdram_sys_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
